// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu
FILELIST = filelist.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qx "all tests passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    input  alu_op_t           alu_op,
    output logic [data_w-1:0] result,
    output logic              zero
);

    logic slt;

    assign slt = $signed(a) < $signed(b);

    always_comb begin
        case (alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_sll: result = a << b[3:0];      // shift amount from low nibble
            alu_slt: result = {{(data_w-1){1'b0}}, slt};
            default: result = '0;
        endcase
    end

    // used by the fetch unit for beq/bne
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  opcode_t opcode,
    output logic    reg_dst,
    output logic    alu_src,
    output logic    mem_to_reg,
    output logic    reg_write,
    output logic    address_src,
    output logic    halt_op,
    output alu_op_t alu_op,
    output mem_op_t mem_op,
    output branch_t branch
);

    always_comb begin
        // defaults describe a nop, each opcode overrides what it needs
        reg_dst     = 1'b0;
        alu_src     = 1'b0;
        mem_to_reg  = 1'b0;
        reg_write   = 1'b0;
        address_src = 1'b0;
        halt_op     = 1'b0;
        alu_op      = alu_add;
        mem_op      = mem_none;
        branch      = br_none;

        case (opcode)
            op_add, op_sub, op_and, op_or, op_xor, op_sll: begin
                reg_dst   = 1'b1;               // three-register form writes rd
                reg_write = 1'b1;
                case (opcode)
                    op_sub:  alu_op = alu_sub;
                    op_and:  alu_op = alu_and;
                    op_or:   alu_op = alu_or;
                    op_xor:  alu_op = alu_xor;
                    op_sll:  alu_op = alu_sll;
                    default: alu_op = alu_add;
                endcase
            end
            op_addi, op_subi, op_slti: begin
                alu_src   = 1'b1;               // sign-extended imm as operand b
                reg_write = 1'b1;
                case (opcode)
                    op_subi: alu_op = alu_sub;
                    op_slti: alu_op = alu_slt;
                    default: alu_op = alu_add;
                endcase
            end
            op_lw, op_lwo: begin
                alu_src     = 1'b1;             // rs+imm for the offset form
                address_src = (opcode == op_lw);
                mem_op      = mem_read;
                mem_to_reg  = 1'b1;
                reg_write   = 1'b1;
            end
            op_sw, op_swo: begin
                alu_src     = 1'b1;
                address_src = (opcode == op_sw);
                mem_op      = mem_write;
            end
            op_beq: begin
                alu_op = alu_sub;               // zero flag gives rs == rt
                branch = br_eq;
            end
            op_bne: begin
                alu_op = alu_sub;
                branch = br_ne;
            end
            op_halt: halt_op = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_en,
    input  logic [3:0]  wb_addr,
    input  logic [15:0] wb_data,
    input  logic [7:0]  pc,
    input  logic        halted,
    input  logic [19:0] exp_wb [64],
    input  int          exp_count,
    input  logic [7:0]  exp_pc,
    input  logic        end_check,
    output int          errors,
    output int          checks
);

    int   idx;
    logic done;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= 0;
            errors <= 0;
            checks <= 0;
            done <= 1'b0;
        end else begin
            if (wb_en) begin
                checks <= checks + 1;
                if (halted) begin
                    $display("error at %0t: write-back while halted", $time);
                    errors <= errors + 1;
                end else if (idx >= exp_count) begin
                    $display("error at %0t: extra write-back r%0d = %h",
                             $time, wb_addr, wb_data);
                    errors <= errors + 1;
                end else if ({wb_addr, wb_data} !== exp_wb[idx]) begin
                    $display("error at %0t: write-back %0d got r%0d = %h, expected r%0d = %h",
                             $time, idx, wb_addr, wb_data,
                             exp_wb[idx][19:16], exp_wb[idx][15:0]);
                    errors <= errors + 1;
                end
                idx <= idx + 1;
            end
            if (end_check && !done) begin
                done <= 1'b1;
                checks <= checks + 1;
                if (idx != exp_count || !halted || pc !== exp_pc) begin
                    // final state after the run
                    $display("error at %0t: end state count %0d/%0d halted %b pc %0d/%0d",
                             $time, idx, exp_count, halted, pc, exp_pc);
                    errors <= errors + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpu_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_chk import cpu_pkg::*; #(
    parameter int aw = 8
) (
    input logic          clk,
    input logic          rst_n,
    input logic          halted,
    input logic          step,
    input logic [aw-1:0] pc,
    input logic          reg_write,
    input mem_op_t       mem_op
);

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else $error("halted fell without reset");

    pc_hold: assert property (@(posedge clk) disable iff (!rst_n) !step |=> $stable(pc))
        else $error("pc moved while not stepping");

    decode_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_write && mem_op == mem_write))
        else $error("register write and memory write decoded together");

endmodule

bind cpu_top cpu_chk #(.aw(imem_aw)) u_chk (
    .clk, .rst_n, .halted, .step, .pc, .reg_write, .mem_op
);

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int data_w     = 16;             // data and instruction word
    localparam int reg_addr_w = 4;              // 16 registers

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_addi = 4'd1,
        op_sub  = 4'd2,
        op_subi = 4'd3,
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_xor  = 4'd6,
        op_lw   = 4'd7,                         // rt <- mem[rs]
        op_sw   = 4'd8,                         // mem[rs] <- rt
        op_sll  = 4'd9,
        op_slti = 4'd10,
        op_lwo  = 4'd11,                        // rt <- mem[rs+imm]
        op_swo  = 4'd12,                        // mem[rs+imm] <- rt
        op_beq  = 4'd13,
        op_bne  = 4'd14,
        op_halt = 4'd15
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_t;

    typedef enum logic [1:0] {br_none, br_eq, br_ne} branch_t;

endpackage

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int imem_aw = 8,
    parameter int dmem_aw = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic                  load_en,
    input  logic [imem_aw-1:0]    load_addr,
    input  logic [data_w-1:0]     load_data,
    output logic [imem_aw-1:0]    pc,
    output logic                  halted,
    output logic                  wb_en,
    output logic [reg_addr_w-1:0] wb_addr,
    output logic [data_w-1:0]     wb_data
);

    logic [data_w-1:0] instr, rs_val, rt_val, imm_ext, alu_b, alu_res, mem_rd;
    logic [dmem_aw-1:0] mem_addr;
    logic reg_dst, alu_src, mem_to_reg, reg_write, address_src, halt_op;
    logic zero, step;
    alu_op_t alu_op;
    mem_op_t mem_op;
    branch_t branch;

    // fields: opcode | rs | rt | rd/imm
    assign imm_ext  = {{(data_w-reg_addr_w){instr[3]}}, instr[3:0]};
    assign alu_b    = alu_src ? imm_ext : rt_val;
    assign mem_addr = address_src ? rs_val[dmem_aw-1:0] : alu_res[dmem_aw-1:0];
    assign wb_en    = reg_write && step;
    assign wb_addr  = reg_dst ? instr[3:0] : instr[7:4];
    assign wb_data  = mem_to_reg ? mem_rd : alu_res;

    instr_mem #(.imem_aw(imem_aw)) u_imem (
        .clk, .load_en, .load_addr, .load_data, .pc, .instr
    );

    control_unit u_ctrl (
        .opcode(opcode_t'(instr[15:12])), .reg_dst, .alu_src, .mem_to_reg,
        .reg_write, .address_src, .halt_op, .alu_op, .mem_op, .branch
    );

    reg_file u_rf (
        .clk, .rst_n, .ra(instr[11:8]), .rb(instr[7:4]), .rd_a(rs_val), .rd_b(rt_val),
        .we(wb_en), .wa(wb_addr), .wd(wb_data)
    );

    alu u_alu (.a(rs_val), .b(alu_b), .alu_op, .result(alu_res), .zero);

    data_mem #(.dmem_aw(dmem_aw)) u_dmem (
        .clk, .rst_n, .addr(mem_addr), .we(mem_op == mem_write && step),
        .wd(rt_val), .rd(mem_rd)
    );

    fetch_unit #(.imem_aw(imem_aw)) u_fetch (
        .clk, .rst_n, .run, .branch, .zero, .imm(instr[3:0]), .halt_op,
        .pc, .halted, .step
    );

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem import cpu_pkg::*; #(
    parameter int dmem_aw = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [dmem_aw-1:0] addr,
    input  logic               we,
    input  logic [data_w-1:0]  wd,
    output logic [data_w-1:0]  rd
);

    logic [data_w-1:0] mem [2**dmem_aw];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**dmem_aw; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wd;
        end
    end

    assign rd = mem[addr];                  // asynchronous read

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
    parameter int imem_aw = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    input  branch_t               branch,
    input  logic                  zero,
    input  logic [reg_addr_w-1:0] imm,
    input  logic                  halt_op,
    output logic [imem_aw-1:0]    pc,
    output logic                  halted,
    output logic                  step
);

    logic               taken;
    logic [imem_aw-1:0] imm_ext;

    assign step    = run && !halted;
    assign taken   = (branch == br_eq && zero) || (branch == br_ne && !zero);
    assign imm_ext = {{(imem_aw-reg_addr_w){imm[reg_addr_w-1]}}, imm};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (step) begin
            if (halt_op) halted <= 1'b1;    // pc holds on the halt word
            else if (taken) pc <= pc + 1'b1 + imm_ext;
            else pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
cpu_pkg.sv
control_unit.sv
alu.sv
reg_file.sv
data_mem.sv
instr_mem.sv
fetch_unit.sv
cpu_top.sv
cpu_chk.sv
cpu_checker.sv
tb_cpu.sv

// ==== instr_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_mem import cpu_pkg::*; #(
    parameter int imem_aw = 8
) (
    input  logic               clk,
    input  logic               load_en,
    input  logic [imem_aw-1:0] load_addr,
    input  logic [data_w-1:0]  load_data,
    input  logic [imem_aw-1:0] pc,
    output logic [data_w-1:0]  instr
);

    logic [data_w-1:0] mem [2**imem_aw];

    // program load port
    always_ff @(posedge clk) begin
        if (load_en) mem[load_addr] <= load_data;
    end

    assign instr = mem[pc];

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] ra,
    input  logic [reg_addr_w-1:0] rb,
    output logic [data_w-1:0]     rd_a,
    output logic [data_w-1:0]     rd_b,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] wa,
    input  logic [data_w-1:0]     wd
);

    logic [data_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // r0 is never written
            regs[wa] <= wd;
        end
    end

    assign rd_a = (ra == '0) ? '0 : regs[ra];
    assign rd_b = (rb == '0) ? '0 : regs[rb];

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

    localparam int prog_len = 41;               // 40 random words and a halt
    localparam int imem_fill = 48;              // halt padding past the end

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        load_en;
    logic [7:0]  load_addr;
    logic [15:0] load_data;
    logic [7:0]  pc;
    logic        halted;
    logic        wb_en;
    logic [3:0]  wb_addr;
    logic [15:0] wb_data;
    logic        end_check;
    int          errors;
    int          checks;
    logic        started;

    logic [15:0] lfsr;
    logic [15:0] prog [imem_fill];
    logic [19:0] exp_wb [64];                   // {addr, data} in commit order
    int          exp_count;
    logic [7:0]  exp_pc;

    cpu_top #(.imem_aw(8), .dmem_aw(8)) DUT (
        .clk, .rst_n, .run, .load_en, .load_addr, .load_data,
        .pc, .halted, .wb_en, .wb_addr, .wb_data
    );

    cpu_checker u_checker (
        .clk, .rst_n, .wb_en, .wb_addr, .wb_data, .pc, .halted,
        .exp_wb, .exp_count, .exp_pc, .end_check, .errors, .checks
    );

    always #50 clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11 and one step per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], b};
            r = {r[14:0], b};
        end
        return r;
    endfunction

    function automatic void build_program();
        logic [3:0] op;
        logic [3:0] rs;
        logic [3:0] rt;
        logic [3:0] imm;
        for (int i = 0; i < prog_len - 1; i++) begin
            op = 4'(take_bits(4));
            if (op == 4'd15) op = 4'd0;         // halt only at the end
            rs = 4'(take_bits(3));
            rt = 4'(take_bits(3));
            if (op == 4'd13 || op == 4'd14) imm = 4'(take_bits(2));  // forward only
            else imm = 4'(take_bits(4));
            prog[i] = {op, rs, rt, imm};
        end
        // halt words with the address in the unused bits
        for (int i = prog_len - 1; i < imem_fill; i++) prog[i] = {4'd15, 12'(i)};
    endfunction

    // software model of the core that fills the expected write-back list
    function automatic void run_model();
        logic [15:0] r [16];
        logic [15:0] m [256];
        logic [15:0] w;
        logic [15:0] rsv;
        logic [15:0] rtv;
        logic [15:0] imm_s;
        logic [15:0] val;
        logic [3:0]  op;
        logic [3:0]  dst;
        logic        wr;
        int          p;
        for (int i = 0; i < 16; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) m[i] = '0;
        p = 0;
        exp_count = 0;
        for (int s = 0; s < 200; s++) begin
            w = prog[p];
            op = w[15:12];
            rsv = r[w[11:8]];
            rtv = r[w[7:4]];
            imm_s = {{12{w[3]}}, w[3:0]};
            wr = 1'b1;
            dst = w[3:0];                       // rd unless the opcode writes rt
            val = '0;
            if (op == 4'd15) break;             // pc stays on the halt word
            case (op)
                4'd0:  val = rsv + rtv;
                4'd1:  val = rsv + imm_s;
                4'd2:  val = rsv - rtv;
                4'd3:  val = rsv - imm_s;
                4'd4:  val = rsv & rtv;
                4'd5:  val = rsv | rtv;
                4'd6:  val = rsv ^ rtv;
                4'd7:  val = m[rsv[7:0]];
                4'd9:  val = rsv << rtv[3:0];
                4'd10: val = ($signed(rsv) < $signed(imm_s)) ? 16'd1 : 16'd0;
                4'd11: val = m[8'(rsv + imm_s)];
                default: wr = 1'b0;
            endcase
            if (op == 4'd1 || op == 4'd3 || op == 4'd7 || op == 4'd10 || op == 4'd11)
                dst = w[7:4];
            if (op == 4'd8) m[rsv[7:0]] = rtv;
            if (op == 4'd12) m[8'(rsv + imm_s)] = rtv;
            if (wr) begin
                exp_wb[exp_count] = {dst, val};
                exp_count++;
                if (dst != 4'd0) r[dst] = val;  // r0 stays zero
            end
            if ((op == 4'd13 && rsv == rtv) || (op == 4'd14 && rsv != rtv))
                p = (p + 1 + int'(w[3:0])) & 255;
            else
                p = (p + 1) & 255;
        end
        exp_pc = 8'(p);
    endfunction

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        end_check = 1'b0;
        started = 1'b0;
        lfsr = 16'd36;
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < imem_fill; i++) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= 8'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        @(posedge clk);
        run <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        while (!halted) @(posedge clk);
        repeat (4) @(posedge clk);              // run stays high past the halt
        end_check <= 1'b1;
        repeat (2) @(posedge clk);
        #1;
        $display("checks %0d errors %0d expected write-backs %0d", checks, errors, exp_count);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (started);
        #((prog_len + 20) * 100);
        $display("timeout, the core did not halt");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
